/* src/cfg_consts.svh */
`ifndef CFG_CONSTS_SVH
`define CFG_CONSTS_SVH

// Command channel widths
`define CFG_ADDR_W 20
`define CFG_DATA_W 64

// Tile coordinate and network ids
`define CORD_X_W 4
`define CORD_Y_W 3
`define CORD_W (`CORD_X_W + `CORD_Y_W)
`define DID_W 3
`define HIO_W 8
`define CORE_ID_W 7
`define LCE_ID_W 8

// Coherence-engine microcode store
`define UCODE_PC_W 8
`define UCODE_INSTR_W 48

// Register map, one 8-byte word per register
`define REG_FREEZE 20'h00000
`define REG_ICACHE_MODE 20'h00008
`define REG_DCACHE_MODE 20'h00010
`define REG_CCE_MODE 20'h00018
`define REG_HIO_MASK 20'h00020
`define REG_CORD 20'h00028
`define REG_DID 20'h00030
`define REG_HOST_DID 20'h00038
`define UCODE_BASE 20'h08000

`define CFG_RD_SEL_N 9 // Readable sources in the response mux

`endif

/* src/cfg_pkg.sv */
`include "cfg_consts.svh"

package cfg_pkg;

  // Uncached single-word opcodes
  typedef enum logic [1:0]
  {
    e_uc_rd = 2'b00,
    e_uc_wr = 2'b01
  } cfg_msg_type_e;

  typedef struct packed
  {
    cfg_msg_type_e           msg_type;
    logic [`CFG_ADDR_W-1:0]  addr;
  } cfg_header_s;

  // Shared by command and response
  typedef struct packed
  {
    cfg_header_s             header;
    logic [`CFG_DATA_W-1:0]  data;
  } cfg_msg_s;

  typedef enum logic [1:0]
  {
    e_lce_uncached = 2'b00,
    e_lce_normal   = 2'b01,
    e_lce_nonspec  = 2'b10
  } lce_mode_e;

  typedef enum logic [0:0]
  {
    e_cce_uncached = 1'b0,
    e_cce_normal   = 1'b1
  } cce_mode_e;

  // Configuration broadcast to the rest of the tile
  typedef struct packed
  {
    logic                    freeze;
    logic [`CORE_ID_W-1:0]   core_id;
    logic [`LCE_ID_W-1:0]    icache_id;
    lce_mode_e               icache_mode;
    logic [`LCE_ID_W-1:0]    dcache_id;
    lce_mode_e               dcache_mode;
    logic [`CORE_ID_W-1:0]   cce_id;
    cce_mode_e               cce_mode;
    logic [`HIO_W-1:0]       hio_mask;
  } cfg_bus_s;

endpackage

/* src/cfg_cmd_buffer.sv */
`timescale 1ns/1ns

module cfg_cmd_buffer
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  cfg_pkg::cfg_msg_s data_i,
  input  logic              v_i,
  output logic              ready_o,
  output cfg_pkg::cfg_msg_s data_o,
  output logic              v_o,
  input  logic              yumi_i
);
  import cfg_pkg::*;

  logic     full_r;
  cfg_msg_s data_r;

  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (v_i & ~full_r)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (v_i & ~full_r)
      data_r <= data_i;
  end

  // A held command is not overwritten before its response is taken
  a_no_load_while_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_o && !yumi_i) |=> (v_o && $stable(data_o)));

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

endmodule

/* src/cord_id_map.sv */
`timescale 1ns/1ns

`include "cfg_consts.svh"

module cord_id_map
(
  input  logic [`CORD_W-1:0]    cord_i,
  output logic [`CORE_ID_W-1:0] core_id_o,
  output logic [`CORE_ID_W-1:0] cce_id_o,
  output logic [`LCE_ID_W-1:0]  icache_id_o,
  output logic [`LCE_ID_W-1:0]  dcache_id_o
);

  logic [`CORD_X_W-1:0] cord_x;
  logic [`CORD_Y_W-1:0] cord_y;

  assign cord_x = cord_i[`CORD_X_W-1:0];
  assign cord_y = cord_i[`CORD_W-1:`CORD_X_W];

  // Row-major id with y above x
  assign core_id_o = {cord_y, cord_x};
  assign cce_id_o  = core_id_o; // One engine per core

  // Each core owns an even/odd pair of cache ids
  assign icache_id_o = {core_id_o, 1'b0};
  assign dcache_id_o = {core_id_o, 1'b1};

endmodule

/* src/ucode_ram.sv */
`timescale 1ns/1ns

`include "cfg_consts.svh"

module ucode_ram
(
  input  logic                      clk_i,
  input  logic                      v_i,
  input  logic                      w_i,
  input  logic [`UCODE_PC_W-1:0]    addr_i,
  input  logic [`UCODE_INSTR_W-1:0] data_i,
  output logic [`UCODE_INSTR_W-1:0] data_o
);

  logic [`UCODE_INSTR_W-1:0] mem [2**`UCODE_PC_W];

  always_ff @(posedge clk_i)
  begin
    if (v_i & w_i)
      mem[addr_i] <= data_i;
  end

  // Read port holds its last word until the next read strobe
  always_ff @(posedge clk_i)
  begin
    if (v_i & ~w_i)
      data_o <= mem[addr_i];
  end

endmodule

/* src/cfg_regs.sv */
`timescale 1ns/1ns

`include "cfg_consts.svh"

module cfg_regs
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  cfg_pkg::cfg_msg_s         cmd_i,
  input  logic                      cmd_v_i,
  output logic                      cmd_yumi_o,

  output cfg_pkg::cfg_msg_s         resp_o,
  output logic                      resp_v_o,
  input  logic                      resp_yumi_i,

  input  logic [`DID_W-1:0]         did_i,
  input  logic [`DID_W-1:0]         host_did_i,
  input  logic [`CORD_W-1:0]        cord_i,

  input  logic [`CORE_ID_W-1:0]     core_id_i,
  input  logic [`CORE_ID_W-1:0]     cce_id_i,
  input  logic [`LCE_ID_W-1:0]      icache_id_i,
  input  logic [`LCE_ID_W-1:0]      dcache_id_i,

  output logic                      ucode_v_o,
  output logic                      ucode_w_o,
  output logic [`UCODE_PC_W-1:0]    ucode_addr_o,
  output logic [`UCODE_INSTR_W-1:0] ucode_data_o,
  input  logic [`UCODE_INSTR_W-1:0] ucode_data_i,

  output cfg_pkg::cfg_bus_s         cfg_bus_o
);
  import cfg_pkg::*;

  logic                     freeze_r;
  lce_mode_e                icache_mode_r;
  lce_mode_e                dcache_mode_r;
  cce_mode_e                cce_mode_r;
  logic [`HIO_W-1:0]        hio_mask_r;

  logic                     resp_v_r;
  logic                     load_r;
  logic [`CFG_RD_SEL_N-1:0] read_sel;
  logic [`CFG_RD_SEL_N-1:0] read_sel_r;
  logic [`CFG_DATA_W-1:0]   read_src [`CFG_RD_SEL_N];
  logic [`CFG_DATA_W-1:0]   read_data;
  logic [`CFG_DATA_W-1:0]   read_data_r;

  logic                     cmd_new;
  logic                     cmd_rd;
  logic                     cmd_wr;
  logic                     ucode_hit;
  logic [`CFG_ADDR_W-1:0]   addr;
  logic [`CFG_DATA_W-1:0]   wdata;

  // Act on a buffered command once, before its response is raised
  assign cmd_new   = cmd_v_i & ~resp_v_r;
  assign cmd_rd    = cmd_new & (cmd_i.header.msg_type == e_uc_rd);
  assign cmd_wr    = cmd_new & (cmd_i.header.msg_type == e_uc_wr);
  assign addr      = cmd_i.header.addr;
  assign wdata     = cmd_i.data;
  assign ucode_hit = (addr >= `UCODE_BASE);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      freeze_r      <= 1'b1;
      icache_mode_r <= e_lce_uncached;
      dcache_mode_r <= e_lce_uncached;
      cce_mode_r    <= e_cce_uncached;
      hio_mask_r    <= '0;
    end
    else if (cmd_wr)
    begin
      case (addr)
        `REG_FREEZE:      freeze_r      <= wdata[0];
        `REG_ICACHE_MODE: icache_mode_r <= lce_mode_e'(wdata[1:0]);
        `REG_DCACHE_MODE: dcache_mode_r <= lce_mode_e'(wdata[1:0]);
        `REG_CCE_MODE:    cce_mode_r    <= cce_mode_e'(wdata[0]);
        `REG_HIO_MASK:    hio_mask_r    <= wdata[`HIO_W-1:0];
        default:          ; // Read-only and unmapped addresses drop the write
      endcase
    end
  end

  assign ucode_v_o    = (cmd_rd | cmd_wr) & ucode_hit;
  assign ucode_w_o    = cmd_wr & ucode_hit;
  assign ucode_addr_o = addr[3 +: `UCODE_PC_W];
  assign ucode_data_o = wdata[`UCODE_INSTR_W-1:0];

  assign cfg_bus_o = '{freeze:      freeze_r,
                       core_id:     core_id_i,
                       icache_id:   icache_id_i,
                       icache_mode: icache_mode_r,
                       dcache_id:   dcache_id_i,
                       dcache_mode: dcache_mode_r,
                       cce_id:      cce_id_i,
                       cce_mode:    cce_mode_r,
                       hio_mask:    hio_mask_r};

  // Read select bit order matches read_src below
  assign read_sel = {cmd_rd & ucode_hit,
                     cmd_rd & (addr == `REG_HOST_DID),
                     cmd_rd & (addr == `REG_DID),
                     cmd_rd & (addr == `REG_CORD),
                     cmd_rd & (addr == `REG_HIO_MASK),
                     cmd_rd & (addr == `REG_CCE_MODE),
                     cmd_rd & (addr == `REG_DCACHE_MODE),
                     cmd_rd & (addr == `REG_ICACHE_MODE),
                     cmd_rd & (addr == `REG_FREEZE)};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      resp_v_r   <= 1'b0;
      load_r     <= 1'b0;
      read_sel_r <= '0;
    end
    else
    begin
      load_r <= cmd_new; // First response cycle only
      if (cmd_new)
      begin
        resp_v_r   <= 1'b1;
        read_sel_r <= read_sel;
      end
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  assign read_src[0] = `CFG_DATA_W'(freeze_r);
  assign read_src[1] = `CFG_DATA_W'(icache_mode_r);
  assign read_src[2] = `CFG_DATA_W'(dcache_mode_r);
  assign read_src[3] = `CFG_DATA_W'(cce_mode_r);
  assign read_src[4] = `CFG_DATA_W'(hio_mask_r);
  assign read_src[5] = `CFG_DATA_W'(cord_i);
  assign read_src[6] = `CFG_DATA_W'(did_i);
  assign read_src[7] = `CFG_DATA_W'(host_did_i);
  assign read_src[8] = `CFG_DATA_W'(ucode_data_i);

  always_comb
  begin
    read_data = '0;
    for (int i = 0; i < `CFG_RD_SEL_N; i++)
    begin
      read_data = read_data | ({`CFG_DATA_W{read_sel_r[i]}} & read_src[i]);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_r)
      read_data_r <= read_data;
  end

  // The mux feeds the response directly in its first cycle, the register after that
  assign resp_o     = '{header: cmd_i.header, data: load_r ? read_data : read_data_r};
  assign resp_v_o   = cmd_v_i & resp_v_r;
  assign cmd_yumi_o = resp_yumi_i;

  a_read_sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(read_sel_r));

  a_resp_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_o)));

endmodule

/* src/cfg_top.sv */
`timescale 1ns/1ns

`include "cfg_consts.svh"

module cfg_top
(
  input  logic              clk_i,
  input  logic              reset_i,

  input  cfg_pkg::cfg_msg_s cmd_i,
  input  logic              cmd_v_i,
  output logic              cmd_ready_o,

  output cfg_pkg::cfg_msg_s resp_o,
  output logic              resp_v_o,
  input  logic              resp_yumi_i,

  output cfg_pkg::cfg_bus_s cfg_bus_o,
  input  logic [`DID_W-1:0] did_i,
  input  logic [`DID_W-1:0] host_did_i,
  input  logic [`CORD_W-1:0] cord_i
);
  import cfg_pkg::*;

  cfg_msg_s                  buf_data;
  logic                      buf_v;
  logic                      buf_yumi;

  logic [`CORE_ID_W-1:0]     core_id;
  logic [`CORE_ID_W-1:0]     cce_id;
  logic [`LCE_ID_W-1:0]      icache_id;
  logic [`LCE_ID_W-1:0]      dcache_id;

  logic                      ucode_v;
  logic                      ucode_w;
  logic [`UCODE_PC_W-1:0]    ucode_addr;
  logic [`UCODE_INSTR_W-1:0] ucode_wdata;
  logic [`UCODE_INSTR_W-1:0] ucode_rdata;

  cfg_cmd_buffer u_cmd_buffer
  (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (cmd_i),
    .v_i     (cmd_v_i),
    .ready_o (cmd_ready_o),
    .data_o  (buf_data),
    .v_o     (buf_v),
    .yumi_i  (buf_yumi)
  );

  cord_id_map u_id_map
  (
    .cord_i      (cord_i),
    .core_id_o   (core_id),
    .cce_id_o    (cce_id),
    .icache_id_o (icache_id),
    .dcache_id_o (dcache_id)
  );

  cfg_regs u_regs
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (buf_data),
    .cmd_v_i      (buf_v),
    .cmd_yumi_o   (buf_yumi),
    .resp_o       (resp_o),
    .resp_v_o     (resp_v_o),
    .resp_yumi_i  (resp_yumi_i),
    .did_i        (did_i),
    .host_did_i   (host_did_i),
    .cord_i       (cord_i),
    .core_id_i    (core_id),
    .cce_id_i     (cce_id),
    .icache_id_i  (icache_id),
    .dcache_id_i  (dcache_id),
    .ucode_v_o    (ucode_v),
    .ucode_w_o    (ucode_w),
    .ucode_addr_o (ucode_addr),
    .ucode_data_o (ucode_wdata),
    .ucode_data_i (ucode_rdata),
    .cfg_bus_o    (cfg_bus_o)
  );

  ucode_ram u_ucode_ram
  (
    .clk_i  (clk_i),
    .v_i    (ucode_v),
    .w_i    (ucode_w),
    .addr_i (ucode_addr),
    .data_i (ucode_wdata),
    .data_o (ucode_rdata)
  );

endmodule

/* test/cfg_tb.sv */
`timescale 1ns/1ns

`include "cfg_consts.svh"

module cfg_tb;
  import cfg_pkg::*;

  typedef struct packed
  {
    logic [7:0]             kind;
    logic [`CFG_ADDR_W-1:0] addr;
    logic [`CFG_DATA_W-1:0] wdata;
    logic [`CFG_DATA_W-1:0] rdata;
    logic                   freeze;
    logic [1:0]             icache_mode;
    logic [1:0]             dcache_mode;
    logic                   cce_mode;
    logic [`HIO_W-1:0]      hio_mask;
  } trace_entry_s;

  localparam logic [`CORD_X_W-1:0] tile_x   = 4'ha;
  localparam logic [`CORD_Y_W-1:0] tile_y   = 3'd5;
  localparam logic [`DID_W-1:0]    tile_did = 3'd2;
  localparam logic [`DID_W-1:0]    host_did = 3'd6;

  logic                clk_i;
  logic                reset_i;
  cfg_msg_s            cmd_i;
  logic                cmd_v_i;
  logic                cmd_ready_o;
  cfg_msg_s            resp_o;
  logic                resp_v_o;
  logic                resp_yumi_i;
  cfg_bus_s            cfg_bus_o;
  logic [`DID_W-1:0]   did_i;
  logic [`DID_W-1:0]   host_did_i;
  logic [`CORD_W-1:0]  cord_i;

  trace_entry_s        trace_q[$];
  int                  cycle_count = 0;
  int                  cycle_limit = 0;

  cfg_top DUT
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (cmd_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .resp_o      (resp_o),
    .resp_v_o    (resp_v_o),
    .resp_yumi_i (resp_yumi_i),
    .cfg_bus_o   (cfg_bus_o),
    .did_i       (did_i),
    .host_did_i  (host_did_i),
    .cord_i      (cord_i)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic report_mismatch(input string what);
    $display("Fail at %0t ns: %s", $time, what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Value mismatch");
  endtask

  task automatic check_resp(input cfg_msg_s got, input cfg_msg_s exp);
    if (got.header !== exp.header)
      report_mismatch($sformatf("response header %h, expected %h", got.header, exp.header));
    else if (exp.header.msg_type == e_uc_rd && got.data !== exp.data)
      report_mismatch($sformatf("read data %h at address %h, expected %h",
                                got.data, exp.header.addr, exp.data));
  endtask

  task automatic check_bus(input cfg_bus_s got, input cfg_bus_s exp);
    if (got !== exp)
      report_mismatch($sformatf("configuration bus %h, expected %h", got, exp));
  endtask

  task automatic check_latency(input int edges);
    if (edges != 2)
      report_mismatch($sformatf("response valid after %0d edges, expected 2", edges));
  endtask

  // Ids follow the coordinate rule: y above x, then an even/odd cache pair
  function automatic cfg_bus_s expected_bus(input trace_entry_s e);
    cfg_bus_s              b;
    logic [`CORE_ID_W-1:0] core;
    logic [`LCE_ID_W-1:0]  icache;
    core   = `CORE_ID_W'(tile_y) * 7'd16 + `CORE_ID_W'(tile_x);
    icache = `LCE_ID_W'(core) * 8'd2;
    b.freeze      = e.freeze;
    b.core_id     = core;
    b.icache_id   = icache;
    b.icache_mode = lce_mode_e'(e.icache_mode);
    b.dcache_id   = icache + 8'd1;
    b.dcache_mode = lce_mode_e'(e.dcache_mode);
    b.cce_id      = core;
    b.cce_mode    = cce_mode_e'(e.cce_mode);
    b.hio_mask    = e.hio_mask;
    return b;
  endfunction

  task automatic load_trace();
    int                  fd;
    int                  code;
    logic                bad;
    logic [7:0]          tok;
    logic [8*160-1:0]    rest;
    logic [63:0]         v0;
    logic [63:0]         v1;
    logic [63:0]         v2;
    logic [63:0]         v3;
    logic [63:0]         v4;
    trace_entry_s        e;
    bad = 1'b0;
    fd  = $fopen("test/cfg_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the trace file test/cfg_trace.txt");
      $display("TESTBENCH FAILED");
      $fatal(1, "Missing trace");
    end
    else
    begin
      while (!$feof(fd) && !bad)
      begin
        code = $fscanf(fd, " %s", tok);
        if (code == 1)
        begin
          e      = '0;
          e.kind = tok;
          if (tok == "#")
            code = $fgets(rest, fd); // Comment line
          else if (tok == "B")
          begin
            code = $fscanf(fd, " %h %h %h %h %h", v0, v1, v2, v3, v4);
            bad  = (code != 5);
            e.freeze      = v0[0];
            e.icache_mode = v1[1:0];
            e.dcache_mode = v2[1:0];
            e.cce_mode    = v3[0];
            e.hio_mask    = v4[`HIO_W-1:0];
            trace_q.push_back(e);
          end
          else if (tok == "R" || tok == "W")
          begin
            code    = $fscanf(fd, " %h %h %h", v0, v1, v2);
            bad     = (code != 3);
            e.addr  = v0[`CFG_ADDR_W-1:0];
            e.wdata = v1;
            e.rdata = v2;
            trace_q.push_back(e);
          end
          else
            bad = 1'b1;
        end
      end
      $fclose(fd);
      if (bad)
      begin
        $display("The trace file has a line that could not be read");
        $display("TESTBENCH FAILED");
        $fatal(1, "Bad trace");
      end
    end
  endtask

  task automatic run_command(input trace_entry_s e);
    cfg_msg_s msg;
    cfg_msg_s exp;
    cfg_msg_s held;
    int       edges;
    int       delay;
    msg.header.msg_type = (e.kind == "W") ? e_uc_wr : e_uc_rd;
    msg.header.addr     = e.addr;
    msg.data            = e.wdata;
    exp.header          = msg.header;
    exp.data            = e.rdata;

    @(posedge clk_i);
    cmd_i   <= msg;
    cmd_v_i <= 1'b1;
    @(negedge clk_i);
    while (!cmd_ready_o)
    begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    @(posedge clk_i); // Command transfers on this edge
    cmd_v_i <= 1'b0;
    edges = 1;
    @(negedge clk_i);
    while (!resp_v_o)
    begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end
    check_latency(edges);

    held = resp_o;
    check_resp(held, exp);

    delay = int'($urandom % 4);
    repeat (delay)
    begin
      @(posedge clk_i);
      @(negedge clk_i);
      if (!resp_v_o || resp_o !== held)
        report_mismatch("response changed before yumi");
      else if (cmd_ready_o)
        report_mismatch("cmd_ready_o high while the response waits");
    end

    @(posedge clk_i);
    resp_yumi_i <= 1'b1;
    @(negedge clk_i);
    if (cmd_ready_o)
      report_mismatch("cmd_ready_o high in the yumi cycle");
    @(posedge clk_i);
    resp_yumi_i <= 1'b0;
    @(negedge clk_i);
    if (resp_v_o)
      report_mismatch("resp_v_o still high after yumi");
    else if (!cmd_ready_o)
      report_mismatch("cmd_ready_o did not rise after yumi");
  endtask

  initial
  begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    cmd_i       = '0;
    cmd_v_i     = 1'b0;
    resp_yumi_i = 1'b0;
    cord_i      = {tile_y, tile_x};
    did_i       = tile_did;
    host_did_i  = host_did;
    void'($urandom(99));

    load_trace();
    cycle_limit = trace_q.size() * 12 + 100;

    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (cmd_ready_o !== 1'b1 || resp_v_o !== 1'b0)
      report_mismatch("handshake outputs wrong after reset");

    foreach (trace_q[i])
    begin
      if (trace_q[i].kind == "B")
        check_bus(cfg_bus_o, expected_bus(trace_q[i]));
      else
        run_command(trace_q[i]);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+src
src/cfg_pkg.sv
src/cfg_cmd_buffer.sv
src/cord_id_map.sv
src/ucode_ram.sv
src/cfg_regs.sv
src/cfg_top.sv
test/cfg_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the configuration slave testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cfg_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vcfg_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi

exit 0

/* test/cfg_trace.txt */
# Commands: op (R read, W write), address, write data, expected read data, all hex
# Bus checks: B freeze icache_mode dcache_mode cce_mode hio_mask, all hex
B 1 0 0 0 00
R 00000 0 1
R 00008 0 0
R 00010 0 0
R 00018 0 0
R 00020 0 0
R 00028 0 5a
R 00030 0 2
R 00038 0 6
W 00008 1 0
W 00010 2 0
W 00018 1 0
W 00020 a5 0
W 00000 0 0
B 0 1 2 1 a5
R 00000 0 0
R 00008 0 1
R 00010 0 2
R 00018 0 1
R 00020 0 a5
W 00028 7f 0
W 00040 ffff 0
R 00028 0 5a
R 00040 0 0
R 00100 0 0
B 0 1 2 1 a5
W 08000 123456789abc 0
W 08008 deadbeef 0
W 087f8 fedcba987654 0
R 08000 0 123456789abc
R 087f8 0 fedcba987654
R 08008 0 deadbeef
W 00020 3c 0
B 0 1 2 1 3c
